//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int opc_w = 5;
	localparam int reg_w = 5;
	localparam int funct3_w = 3;
	localparam int funct7_w = 7;
	// upper immediate of U and J words
	localparam int uimm_w = 20;

	// major opcodes, bits [6:2] of the word
	localparam logic [opc_w-1:0] op_load = 5'b00000;
	localparam logic [opc_w-1:0] op_op_imm = 5'b00100;
	localparam logic [opc_w-1:0] op_op_imm_32 = 5'b00110;
	localparam logic [opc_w-1:0] op_store = 5'b01000;
	localparam logic [opc_w-1:0] op_op = 5'b01100;
	localparam logic [opc_w-1:0] op_lui = 5'b01101;
	localparam logic [opc_w-1:0] op_op_32 = 5'b01110;
	localparam logic [opc_w-1:0] op_branch = 5'b11000;
	localparam logic [opc_w-1:0] op_jalr = 5'b11001;
	localparam logic [opc_w-1:0] op_jal = 5'b11011;
	localparam logic [opc_w-1:0] op_system = 5'b11100;

	typedef logic [reg_w-1:0] reg_idx_t;

	typedef struct packed {
		logic [funct7_w-1:0] funct7;
		reg_idx_t rs2;
		reg_idx_t rs1;
		logic [funct3_w-1:0] funct3;
		reg_idx_t rd;
		logic [opc_w-1:0] opcode;
		logic [1:0] quad;
	} r_fmt_s;

	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t rs1;
		logic [funct3_w-1:0] funct3;
		reg_idx_t rd;
		logic [opc_w-1:0] opcode;
		logic [1:0] quad;
	} i_fmt_s;

	typedef struct packed {
		logic [6:0] imm_hi;
		reg_idx_t rs2;
		reg_idx_t rs1;
		logic [funct3_w-1:0] funct3;
		logic [4:0] imm_lo;
		logic [opc_w-1:0] opcode;
		logic [1:0] quad;
	} s_fmt_s;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		reg_idx_t rs2;
		reg_idx_t rs1;
		logic [funct3_w-1:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		logic [opc_w-1:0] opcode;
		logic [1:0] quad;
	} b_fmt_s;

	typedef struct packed {
		logic [uimm_w-1:0] imm;
		reg_idx_t rd;
		logic [opc_w-1:0] opcode;
		logic [1:0] quad;
	} u_fmt_s;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		reg_idx_t rd;
		logic [opc_w-1:0] opcode;
		logic [1:0] quad;
	} j_fmt_s;

	// one 32-bit instruction, seen through each base format
	typedef union packed {
		r_fmt_s r;
		i_fmt_s i;
		s_fmt_s s;
		b_fmt_s b;
		u_fmt_s u;
		j_fmt_s j;
		logic [31:0] raw;
	} rv_word_u;

endpackage

//--- common/rvc_pkg.sv
package rvc_pkg;

	// compressed kinds that need their own operand layout
	typedef enum logic [4:0] {
		kind_illegal = 5'd0,
		kind_addi4spn,
		// lw/ld and sw/sd share a kind, funct3 bit 0 picks the width
		kind_load,
		kind_store,
		kind_addi,
		kind_addiw,
		kind_jal,
		kind_li,
		kind_addi16sp,
		kind_lui,
		// srli and srai
		kind_shift_r,
		kind_andi,
		// sub, xor, or, and, subw, addw
		kind_arith,
		kind_j,
		// beqz and bnez
		kind_branch,
		kind_slli,
		kind_load_sp,
		kind_store_sp,
		kind_ebreak,
		kind_jr,
		kind_jalr,
		kind_mv,
		kind_add
	} rvc_kind_e;

	typedef enum logic [2:0] {
		fmt_r,
		fmt_i,
		fmt_s,
		fmt_b,
		fmt_u,
		fmt_j
	} rv_fmt_e;

endpackage

//--- decoder/rvc_classifier.sv
module rvc_classifier
	import rv_isa_pkg::*;
	import rvc_pkg::*;
#(
	parameter bit xlen_64 = 1'b1
) (
	input logic [15:0] instr_i,
	output rvc_kind_e kind_o,
	output rv_fmt_e fmt_o,
	output logic [opc_w-1:0] opcode_o,
	output logic [funct3_w-1:0] funct3_o,
	output logic [funct7_w-1:0] funct7_o,
	output logic illegal_o
);

	always_comb begin
		kind_o = kind_illegal;
		fmt_o = fmt_i;
		opcode_o = op_op_imm;
		funct3_o = 3'b000;
		funct7_o = 7'b0000000;

		priority casez (instr_i)
			16'b0000000000000000: kind_o = kind_illegal;

			16'b000_????????_???_00: kind_o = kind_addi4spn;

			// lw, ld only on rv64
			16'b01?_???_???_??_???_00: begin
				if (xlen_64 || !instr_i[13]) begin
					kind_o = kind_load;
					opcode_o = op_load;
					funct3_o = {2'b01, instr_i[13]};
				end
			end

			// sw, sd only on rv64
			16'b11?_???_???_??_???_00: begin
				if (xlen_64 || !instr_i[13]) begin
					kind_o = kind_store;
					fmt_o = fmt_s;
					opcode_o = op_store;
					funct3_o = {2'b01, instr_i[13]};
				end
			end

			16'b000_?_?????_?????_01: kind_o = kind_addi;

			16'b001_?_?????_?????_01: begin
				if (xlen_64) begin
					kind_o = kind_addiw;
					opcode_o = op_op_imm_32;
				end else begin
					kind_o = kind_jal;
					fmt_o = fmt_j;
					opcode_o = op_jal;
				end
			end

			16'b010_?_?????_?????_01: kind_o = kind_li;

			16'b011_?_00010_?????_01: kind_o = kind_addi16sp;

			16'b011_?_?????_?????_01: begin
				kind_o = kind_lui;
				fmt_o = fmt_u;
				opcode_o = op_lui;
			end

			// srli, srai sets funct7 bit 5
			16'b100_?_0?_???_?????_01: begin
				kind_o = kind_shift_r;
				funct3_o = 3'b101;
				funct7_o = {1'b0, instr_i[10], 5'b00000};
			end

			16'b100_?_10_???_?????_01: begin
				kind_o = kind_andi;
				funct3_o = 3'b111;
			end

			// sub xor or and
			16'b100_0_11_???_??_???_01: begin
				kind_o = kind_arith;
				fmt_o = fmt_r;
				opcode_o = op_op;
				funct3_o = {|instr_i[6:5], instr_i[6], &instr_i[6:5]};
				funct7_o = {1'b0, ~|instr_i[6:5], 5'b00000};
			end

			// subw, addw
			16'b100_1_11_???_0?_???_01: begin
				if (xlen_64) begin
					kind_o = kind_arith;
					fmt_o = fmt_r;
					opcode_o = op_op_32;
					funct7_o = {1'b0, ~instr_i[5], 5'b00000};
				end
			end

			16'b101_???????????_01: begin
				kind_o = kind_j;
				fmt_o = fmt_j;
				opcode_o = op_jal;
			end

			16'b11?_???_???_?????_01: begin
				kind_o = kind_branch;
				fmt_o = fmt_b;
				opcode_o = op_branch;
				funct3_o = {2'b00, instr_i[13]};
			end

			16'b000_?_?????_?????_10: begin
				kind_o = kind_slli;
				funct3_o = 3'b001;
			end

			// lwsp, ldsp only on rv64
			16'b01?_?_?????_?????_10: begin
				if (xlen_64 || !instr_i[13]) begin
					kind_o = kind_load_sp;
					opcode_o = op_load;
					funct3_o = {2'b01, instr_i[13]};
				end
			end

			16'b100_1_00000_00000_10: begin
				kind_o = kind_ebreak;
				fmt_o = fmt_r;
				opcode_o = op_system;
			end

			// ebreak-like with other fields set, or jr x0
			16'b100_?_00000_?????_10: kind_o = kind_illegal;

			16'b100_?_?????_00000_10: begin
				kind_o = instr_i[12] ? kind_jalr : kind_jr;
				opcode_o = op_jalr;
			end

			16'b100_?_?????_?????_10: begin
				kind_o = instr_i[12] ? kind_add : kind_mv;
				fmt_o = fmt_r;
				opcode_o = op_op;
			end

			// swsp, sdsp only on rv64
			16'b11?_??????_?????_10: begin
				if (xlen_64 || !instr_i[13]) begin
					kind_o = kind_store_sp;
					fmt_o = fmt_s;
					opcode_o = op_store;
					funct3_o = {2'b01, instr_i[13]};
				end
			end

			// fp loads/stores, zcb and quadrant 3 land here
			default: kind_o = kind_illegal;
		endcase
	end

	assign illegal_o = (kind_o == kind_illegal);

endmodule

//--- decoder/rvc_operand_extract.sv
module rvc_operand_extract
	import rv_isa_pkg::*;
	import rvc_pkg::*;
#(
	parameter bit xlen_64 = 1'b1
) (
	input logic [15:0] instr_i,
	input rvc_kind_e kind_i,
	output reg_idx_t rd_o,
	output reg_idx_t rs1_o,
	output reg_idx_t rs2_o,
	output logic [uimm_w-1:0] imm_o
);

	localparam reg_idx_t x0 = 5'd0;
	localparam reg_idx_t ra = 5'd1;
	localparam reg_idx_t sp = 5'd2;

	reg_idx_t rd_full;
	reg_idx_t rs2_full;
	reg_idx_t rd_prime;
	reg_idx_t rs2_prime;
	logic dword;
	logic [uimm_w-1:0] imm6_s;

	assign rd_full = instr_i[11:7];
	assign rs2_full = instr_i[6:2];
	// 3-bit fields name x8..x15
	assign rd_prime = {2'b01, instr_i[9:7]};
	assign rs2_prime = {2'b01, instr_i[4:2]};
	// doubleword scaling for ld/sd forms
	assign dword = xlen_64 && instr_i[13];
	assign imm6_s = uimm_w'($signed({instr_i[12], instr_i[6:2]}));

	always_comb begin
		rd_o = rd_full;
		rs1_o = rd_full;
		rs2_o = rs2_full;
		imm_o = '0;

		case (kind_i)
			kind_addi4spn: begin
				rd_o = rs2_prime;
				rs1_o = sp;
				imm_o = uimm_w'({instr_i[10:7], instr_i[12:11], instr_i[5], instr_i[6], 2'b00});
			end
			kind_load, kind_store: begin
				rd_o = rs2_prime;
				rs1_o = rd_prime;
				rs2_o = rs2_prime;
				if (dword)
					imm_o = uimm_w'({instr_i[6:5], instr_i[12:10], 3'b000});
				else
					imm_o = uimm_w'({instr_i[5], instr_i[12:10], instr_i[6], 2'b00});
			end
			kind_addi, kind_addiw, kind_lui: imm_o = imm6_s;
			kind_li: begin
				rs1_o = x0;
				imm_o = imm6_s;
			end
			kind_addi16sp: begin
				rd_o = sp;
				rs1_o = sp;
				imm_o = uimm_w'($signed({instr_i[12], instr_i[4:3], instr_i[5], instr_i[2],
					instr_i[6], 4'b0000}));
			end
			kind_shift_r: begin
				rd_o = rd_prime;
				rs1_o = rd_prime;
				imm_o = uimm_w'({instr_i[12], instr_i[6:2]});
			end
			kind_andi: begin
				rd_o = rd_prime;
				rs1_o = rd_prime;
				imm_o = imm6_s;
			end
			kind_arith: begin
				rd_o = rd_prime;
				rs1_o = rd_prime;
				rs2_o = rs2_prime;
			end
			// jump offset in halfwords
			kind_jal, kind_j: begin
				rd_o = (kind_i == kind_jal) ? ra : x0;
				imm_o = uimm_w'($signed({instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
					instr_i[7], instr_i[2], instr_i[11], instr_i[5:3]}));
			end
			kind_branch: begin
				rs1_o = rd_prime;
				rs2_o = x0;
				imm_o = uimm_w'($signed({instr_i[12], instr_i[6:5], instr_i[2], instr_i[11:10],
					instr_i[4:3]}));
			end
			kind_slli: imm_o = uimm_w'({instr_i[12], instr_i[6:2]});
			kind_load_sp: begin
				rs1_o = sp;
				if (dword)
					imm_o = uimm_w'({instr_i[4:2], instr_i[12], instr_i[6:5], 3'b000});
				else
					imm_o = uimm_w'({instr_i[3:2], instr_i[12], instr_i[6:4], 2'b00});
			end
			kind_store_sp: begin
				rs1_o = sp;
				if (dword)
					imm_o = uimm_w'({instr_i[9:7], instr_i[12:10], 3'b000});
				else
					imm_o = uimm_w'({instr_i[8:7], instr_i[12:9], 2'b00});
			end
			// imm of 1 sits in the rs2 slot
			kind_ebreak: begin
				rd_o = x0;
				rs1_o = x0;
				rs2_o = ra;
			end
			kind_jr, kind_jalr: rd_o = (kind_i == kind_jalr) ? ra : x0;
			kind_mv: rs1_o = x0;
			default: ;
		endcase
	end

endmodule

//--- hw/rv_format_pack.sv
module rv_format_pack
	import rv_isa_pkg::*;
	import rvc_pkg::*;
(
	input rv_fmt_e fmt_i,
	input logic [opc_w-1:0] opcode_i,
	input logic [funct3_w-1:0] funct3_i,
	input logic [funct7_w-1:0] funct7_i,
	input reg_idx_t rd_i,
	input reg_idx_t rs1_i,
	input reg_idx_t rs2_i,
	input logic [uimm_w-1:0] imm_i,
	output rv_word_u word_o
);

	always_comb begin
		word_o.raw = '0;

		case (fmt_i)
			rvc_pkg::fmt_r: begin
				word_o.r.funct7 = funct7_i;
				word_o.r.rs2 = rs2_i;
				word_o.r.rs1 = rs1_i;
				word_o.r.funct3 = funct3_i;
				word_o.r.rd = rd_i;
			end
			rvc_pkg::fmt_i: begin
				// shift immediates carry funct7 in the top bits
				word_o.i.imm = imm_i[11:0] | {funct7_i, 5'b00000};
				word_o.i.rs1 = rs1_i;
				word_o.i.funct3 = funct3_i;
				word_o.i.rd = rd_i;
			end
			rvc_pkg::fmt_s: begin
				word_o.s.imm_hi = imm_i[11:5];
				word_o.s.rs2 = rs2_i;
				word_o.s.rs1 = rs1_i;
				word_o.s.funct3 = funct3_i;
				word_o.s.imm_lo = imm_i[4:0];
			end
			// imm holds offset[12:1]
			rvc_pkg::fmt_b: begin
				word_o.b.imm_12 = imm_i[11];
				word_o.b.imm_10_5 = imm_i[9:4];
				word_o.b.rs2 = rs2_i;
				word_o.b.rs1 = rs1_i;
				word_o.b.funct3 = funct3_i;
				word_o.b.imm_4_1 = imm_i[3:0];
				word_o.b.imm_11 = imm_i[10];
			end
			rvc_pkg::fmt_u: begin
				word_o.u.imm = imm_i;
				word_o.u.rd = rd_i;
			end
			// imm holds offset[20:1]
			rvc_pkg::fmt_j: begin
				word_o.j.imm_20 = imm_i[19];
				word_o.j.imm_10_1 = imm_i[9:0];
				word_o.j.imm_11 = imm_i[10];
				word_o.j.imm_19_12 = imm_i[18:11];
				word_o.j.rd = rd_i;
			end
			default: ;
		endcase

		// opcode and quadrant sit at the same place in every view
		word_o.r.opcode = opcode_i;
		word_o.r.quad = 2'b11;
	end

endmodule

//--- hw/rvc_output_stage.sv
module rvc_output_stage
	import rv_isa_pkg::*;
(
	input logic clk_i,
	input logic reset_i,
	input logic valid_i,
	input logic [31:0] instr_i,
	input rv_word_u word_i,
	input logic illegal_i,
	output logic valid_o,
	output logic illegal_o,
	output logic compressed_o,
	output rv_word_u instr_o
);

	logic compressed;
	rv_word_u next_word;

	assign compressed = ~&instr_i[1:0];

	always_comb begin
		if (!compressed)
			next_word.raw = instr_i;
		else if (illegal_i)
			next_word.raw = '0;
		else
			next_word = word_i;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			valid_o <= 1'b0;
			illegal_o <= 1'b0;
			compressed_o <= 1'b0;
			instr_o <= '0;
		end else begin
			valid_o <= valid_i;
			// data holds while no word is offered
			if (valid_i) begin
				illegal_o <= compressed && illegal_i;
				compressed_o <= compressed;
				instr_o <= next_word;
			end
		end
	end

endmodule

//--- hw/rvc_expander.sv
module rvc_expander
	import rv_isa_pkg::*;
	import rvc_pkg::*;
#(
	parameter bit xlen_64 = 1'b1
) (
	input logic clk_i,
	input logic reset_i,
	input logic valid_i,
	input logic [31:0] instr_i,
	output logic valid_o,
	output logic illegal_o,
	output logic compressed_o,
	output rv_word_u instr_o
);

	rvc_kind_e kind;
	rv_fmt_e fmt;
	logic [opc_w-1:0] opcode;
	logic [funct3_w-1:0] funct3;
	logic [funct7_w-1:0] funct7;
	logic illegal;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	logic [uimm_w-1:0] imm;
	rv_word_u packed_word;

	rvc_classifier #(
		.xlen_64(xlen_64)
	) classifier_i (
		.instr_i(instr_i[15:0]),
		.kind_o(kind),
		.fmt_o(fmt),
		.opcode_o(opcode),
		.funct3_o(funct3),
		.funct7_o(funct7),
		.illegal_o(illegal)
	);

	rvc_operand_extract #(
		.xlen_64(xlen_64)
	) operand_extract_i (
		.instr_i(instr_i[15:0]),
		.kind_i(kind),
		.rd_o(rd),
		.rs1_o(rs1),
		.rs2_o(rs2),
		.imm_o(imm)
	);

	rv_format_pack format_pack_i (
		.fmt_i(fmt),
		.opcode_i(opcode),
		.funct3_i(funct3),
		.funct7_i(funct7),
		.rd_i(rd),
		.rs1_i(rs1),
		.rs2_i(rs2),
		.imm_i(imm),
		.word_o(packed_word)
	);

	rvc_output_stage output_stage_i (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.valid_i(valid_i),
		.instr_i(instr_i),
		.word_i(packed_word),
		.illegal_i(illegal),
		.valid_o(valid_o),
		.illegal_o(illegal_o),
		.compressed_o(compressed_o),
		.instr_o(instr_o)
	);

endmodule

//--- testbench/tb_rvc_ref.svh
`ifndef TB_RVC_REF_SVH
`define TB_RVC_REF_SVH

// base formats, built field by field
function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] btype(input logic [12:0] off, input logic [4:0] rs1,
	input logic [2:0] f3);
	return {off[12], off[10:5], 5'd0, rs1, f3, off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] jtype(input logic [20:0] off, input logic [4:0] rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
endfunction

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic void rvc_ref_expand(input logic [31:0] w, input bit x64,
	output logic [31:0] exp_word, output logic exp_ill, output logic exp_comp);
	logic [15:0] c;
	logic [4:0] rdf;
	logic [4:0] rs2f;
	logic [4:0] rdp;
	logic [4:0] rs2p;
	logic [11:0] imm6;
	logic [20:0] joff;
	logic ill;
	logic [31:0] r;
	c = w[15:0];
	rdf = c[11:7];
	rs2f = c[6:2];
	rdp = {2'b01, c[9:7]};
	rs2p = {2'b01, c[4:2]};
	imm6 = {{6{c[12]}}, c[12], c[6:2]};
	joff = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
	ill = 1'b0;
	r = 32'h0;
	exp_comp = (w[1:0] != 2'b11);
	case ({c[15:13], c[1:0]})
		5'b000_00: r = itype({2'b0, c[10:7], c[12:11], c[5], c[6], 2'b0}, 5'd2, 3'd0, rs2p, 7'h13);
		5'b010_00: r = itype({5'b0, c[5], c[12:10], c[6], 2'b0}, rdp, 3'd2, rs2p, 7'h03);
		5'b011_00: if (x64) r = itype({4'b0, c[6:5], c[12:10], 3'b0}, rdp, 3'd3, rs2p, 7'h03);
			else ill = 1'b1;
		5'b110_00: r = stype({5'b0, c[5], c[12:10], c[6], 2'b0}, rs2p, rdp, 3'd2);
		5'b111_00: if (x64) r = stype({4'b0, c[6:5], c[12:10], 3'b0}, rs2p, rdp, 3'd3);
			else ill = 1'b1;
		5'b000_01: r = itype(imm6, rdf, 3'd0, rdf, 7'h13);
		5'b001_01: r = x64 ? itype(imm6, rdf, 3'd0, rdf, 7'h1b) : jtype(joff, 5'd1);
		5'b010_01: r = itype(imm6, 5'd0, 3'd0, rdf, 7'h13);
		5'b011_01: begin
			if (rdf == 5'd2)
				r = itype({{2{c[12]}}, c[12], c[4:3], c[5], c[2], c[6], 4'b0}, 5'd2, 3'd0,
					5'd2, 7'h13);
			else
				r = {{14{c[12]}}, c[12], c[6:2], rdf, 7'h37};
		end
		5'b100_01: begin
			case (c[11:10])
				2'b00: r = itype({6'b000000, c[12], c[6:2]}, rdp, 3'd5, rdp, 7'h13);
				2'b01: r = itype({6'b010000, c[12], c[6:2]}, rdp, 3'd5, rdp, 7'h13);
				2'b10: r = itype(imm6, rdp, 3'd7, rdp, 7'h13);
				default: begin
					if (!c[12])
						case (c[6:5])
							2'b00: r = rtype(7'h20, rs2p, rdp, 3'd0, rdp, 7'h33);
							2'b01: r = rtype(7'h00, rs2p, rdp, 3'd4, rdp, 7'h33);
							2'b10: r = rtype(7'h00, rs2p, rdp, 3'd6, rdp, 7'h33);
							default: r = rtype(7'h00, rs2p, rdp, 3'd7, rdp, 7'h33);
						endcase
					else if (x64 && !c[6])
						r = rtype(c[5] ? 7'h00 : 7'h20, rs2p, rdp, 3'd0, rdp, 7'h3b);
					else
						ill = 1'b1;
				end
			endcase
		end
		5'b101_01: r = jtype(joff, 5'd0);
		5'b110_01, 5'b111_01: r = btype({{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3],
			1'b0}, rdp, {2'b00, c[13]});
		5'b000_10: r = itype({6'b0, c[12], c[6:2]}, rdf, 3'd1, rdf, 7'h13);
		5'b010_10: r = itype({4'b0, c[3:2], c[12], c[6:4], 2'b0}, 5'd2, 3'd2, rdf, 7'h03);
		5'b011_10: if (x64) r = itype({3'b0, c[4:2], c[12], c[6:5], 3'b0}, 5'd2, 3'd3, rdf, 7'h03);
			else ill = 1'b1;
		5'b100_10: begin
			if (rdf == 5'd0) begin
				if (c[12] && rs2f == 5'd0)
					r = 32'h00100073;
				else
					ill = 1'b1;
			end else if (rs2f == 5'd0)
				r = itype(12'd0, rdf, 3'd0, c[12] ? 5'd1 : 5'd0, 7'h67);
			else
				r = rtype(7'h00, rs2f, c[12] ? rdf : 5'd0, 3'd0, rdf, 7'h33);
		end
		5'b110_10: r = stype({4'b0, c[8:7], c[12:9], 2'b0}, rs2f, 5'd2, 3'd2);
		5'b111_10: if (x64) r = stype({3'b0, c[9:7], c[12:10], 3'b0}, rs2f, 5'd2, 3'd3);
			else ill = 1'b1;
		// fp forms, zcb and reserved slots
		default: ill = 1'b1;
	endcase
	if (c == 16'h0000)
		ill = 1'b1;
	if (!exp_comp) begin
		exp_word = w;
		exp_ill = 1'b0;
	end else begin
		exp_word = ill ? 32'h0 : r;
		exp_ill = ill;
	end
endfunction

`endif

//--- testbench/tb_rvc_expander.sv
module tb_rvc_expander
	import rv_isa_pkg::*;
#(
	parameter bit xlen_64 = 1'b1
);

	`include "tb_rvc_ref.svh"

	logic clk;
	logic reset;
	logic valid_in;
	logic [31:0] instr_in;
	logic valid_o;
	logic illegal_o;
	logic compressed_o;
	rv_word_u instr_o;

	logic [31:0] rng;
	int cyc;
	int errors;
	int in_count;
	int out_count;
	bit hung;
	logic [31:0] exp_word_q[$];
	logic exp_ill_q[$];
	logic exp_comp_q[$];
	logic [31:0] exp_src_q[$];
	int exp_cyc_q[$];
	rv_word_u last_word;
	logic last_ill;
	logic last_comp;

	rvc_expander #(
		.xlen_64(xlen_64)
	) dut_i (
		.clk_i(clk),
		.reset_i(reset),
		.valid_i(valid_in),
		.instr_i(instr_in),
		.valid_o(valid_o),
		.illegal_o(illegal_o),
		.compressed_o(compressed_o),
		.instr_o(instr_o)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	task automatic check_word(input rv_word_u got, input rv_word_u exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s word %h, expected %h", $time, what, got.raw, exp.raw);
			errors++;
		end
	endtask

	task automatic check_flags(input logic got_ill, input logic got_comp, input logic exp_ill,
		input logic exp_comp, input string what);
		if (got_ill !== exp_ill || got_comp !== exp_comp) begin
			$display("mismatch at %0t: %s illegal/compressed %b%b, expected %b%b", $time, what,
				got_ill, got_comp, exp_ill, exp_comp);
			errors++;
		end
	endtask

	// compares on the falling edge, away from the update
	always @(negedge clk) begin
		logic [31:0] src;
		logic [31:0] ew;
		logic ei;
		logic ec;
		logic due;
		if (reset) begin
			if (valid_o !== 1'b0 || illegal_o !== 1'b0 || compressed_o !== 1'b0 ||
				instr_o.raw !== 32'h0) begin
				$display("mismatch at %0t: outputs are not cleared during reset", $time);
				errors++;
			end
			last_word = '0;
			last_ill = 1'b0;
			last_comp = 1'b0;
		end else begin
			// a word is due one cycle after the edge that samples it
			due = exp_cyc_q.size() != 0 && exp_cyc_q[0] + 2 == cyc;
			if (valid_o !== due) begin
				$display("mismatch at %0t: valid_o is %b, expected %b", $time, valid_o, due);
				errors++;
			end
			if (valid_o === 1'b1) begin
				if (exp_word_q.size() == 0) begin
					$display("valid_o is high at %0t with no word in flight", $time);
					errors++;
				end else begin
					src = exp_src_q.pop_front();
					ew = exp_word_q.pop_front();
					ei = exp_ill_q.pop_front();
					ec = exp_comp_q.pop_front();
					check_word(instr_o, ew, $sformatf("input %h", src));
					check_flags(illegal_o, compressed_o, ei, ec, $sformatf("input %h", src));
					if (exp_cyc_q.pop_front() + 2 != cyc) begin
						$display("word %h came out at the wrong cycle at %0t", src, $time);
						errors++;
					end
					out_count++;
					last_word = ew;
					last_ill = ei;
					last_comp = ec;
				end
			end else begin
				check_word(instr_o, last_word, "held");
				check_flags(illegal_o, compressed_o, last_ill, last_comp, "held");
			end
		end
	end

	task automatic send_word(input logic [31:0] w);
		logic [31:0] ew;
		logic ei;
		logic ec;
		rvc_ref_expand(w, xlen_64, ew, ei, ec);
		@(posedge clk);
		valid_in <= 1'b1;
		instr_in <= w;
		exp_word_q.push_back(ew);
		exp_ill_q.push_back(ei);
		exp_comp_q.push_back(ec);
		exp_src_q.push_back(w);
		exp_cyc_q.push_back(cyc);
		in_count++;
	endtask

	// idle cycle with junk on the data input
	task automatic send_idle();
		rng = lcg_next(rng);
		@(posedge clk);
		valid_in <= 1'b0;
		instr_in <= rng;
	endtask

	function automatic logic [31:0] rand_word();
		logic [15:0] hi;
		rng = lcg_next(rng);
		hi = rng[31:16];
		rng = lcg_next(rng);
		return {hi, rng[31:16]};
	endfunction

	task automatic finish_test(input string name, input int first_err);
		int n;
		send_idle();
		n = 0;
		while (exp_word_q.size() != 0 && n < 50) begin
			@(negedge clk);
			n++;
		end
		if (exp_word_q.size() != 0) begin
			$display("timeout: %s still has %0d words in flight", name, exp_word_q.size());
			hung = 1'b1;
		end
		$display("%s done: %0d errors", name, errors - first_err);
	endtask

	task automatic run_directed();
		logic [15:0] common_set[24] = '{16'h0040, 16'h4398, 16'hc398, 16'h0505, 16'h4505,
			16'h7139, 16'h6505, 16'h8105, 16'h8505, 16'h8905, 16'h8d0d, 16'h8d2d, 16'h8d4d,
			16'h8d6d, 16'ha011, 16'hc109, 16'he109, 16'h0506, 16'h4512, 16'hc22a, 16'h8082,
			16'h9502, 16'h852e, 16'h952e};
		logic [15:0] rv64_set[7] = '{16'h2505, 16'h6398, 16'he398, 16'h6512, 16'he22a,
			16'h9d0d, 16'h9d2d};
		logic [31:0] ew;
		logic ei;
		logic ec;
		int e0;
		e0 = errors;
		// spot values straight from the ISA manual
		rvc_ref_expand(32'h8082, xlen_64, ew, ei, ec);
		if (ew !== 32'h00008067) errors++;
		rvc_ref_expand(32'h9002, xlen_64, ew, ei, ec);
		if (ew !== 32'h00100073) errors++;
		rvc_ref_expand(32'h4505, xlen_64, ew, ei, ec);
		if (ew !== 32'h00100513) errors++;
		if (errors != e0)
			$display("reference model disagrees with known encodings");
		foreach (common_set[k])
			send_word({16'h0, common_set[k]});
		if (xlen_64) begin
			foreach (rv64_set[k])
				send_word({16'h0, rv64_set[k]});
		end else
			send_word(32'h2011);
		send_word(32'h9002);
		finish_test("directed", e0);
	endtask

	task automatic run_illegal();
		logic [15:0] bad[11] = '{16'h0000, 16'h9d4d, 16'h2398, 16'ha398, 16'h2512, 16'ha22a,
			16'h8398, 16'h9d61, 16'h9d75, 16'h8002, 16'h8000};
		logic [15:0] rv32_bad[8] = '{16'h6398, 16'he398, 16'h6512, 16'he22a, 16'h9d0d,
			16'h9d2d, 16'h6000, 16'he000};
		int e0;
		e0 = errors;
		foreach (bad[k])
			send_word({16'h0, bad[k]});
		if (!xlen_64) begin
			foreach (rv32_bad[k])
				send_word({16'h0, rv32_bad[k]});
		end
		finish_test("illegal", e0);
	endtask

	task automatic run_passthrough();
		int e0;
		e0 = errors;
		repeat (50)
			send_word(rand_word() | 32'h3);
		finish_test("passthrough", e0);
	endtask

	task automatic run_stream();
		int e0;
		e0 = errors;
		repeat (2000)
			send_word(rand_word());
		finish_test("stream", e0);
	endtask

	task automatic run_gaps();
		int e0;
		e0 = errors;
		repeat (300) begin
			rng = lcg_next(rng);
			if (rng[30])
				send_word(rand_word());
			else
				send_idle();
		end
		finish_test("gaps", e0);
	endtask

	task automatic finish_run();
		if (in_count != out_count) begin
			$display("%0d words went in but %0d came out", in_count, out_count);
			errors++;
		end
		$display("words in %0d, out %0d, errors %0d", in_count, out_count, errors);
		if (errors == 0 && !hung)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		valid_in = 1'b0;
		instr_in = 32'h0;
		cyc = 0;
		errors = 0;
		in_count = 0;
		out_count = 0;
		hung = 1'b0;
		rng = 32'h96240b3c;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		send_idle();
		send_idle();
		if (!hung) run_directed();
		if (!hung) run_illegal();
		if (!hung) run_passthrough();
		if (!hung) run_stream();
		if (!hung) run_gaps();
		finish_run();
	end

endmodule

//--- list.f
+incdir+testbench
common/rv_isa_pkg.sv
common/rvc_pkg.sv
decoder/rvc_classifier.sv
decoder/rvc_operand_extract.sv
hw/rv_format_pack.sv
hw/rvc_output_stage.sv
hw/rvc_expander.sv
testbench/tb_rvc_expander.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

for x in 0 1; do
	rm -rf "obj_dir_x$x"
	verilator --binary -Gxlen_64=$x -f list.f --top-module tb_rvc_expander -Mdir "obj_dir_x$x"
	"./obj_dir_x$x/Vtb_rvc_expander" > "sim_x$x.log" 2>&1
	cat "sim_x$x.log"
	if grep -q "Test failed" "sim_x$x.log"; then
		echo "xlen_64=$x: simulation reported failure"
		exit 1
	fi
	if ! grep -q "Test passed" "sim_x$x.log"; then
		echo "xlen_64=$x: simulation did not finish"
		exit 1
	fi
done
echo "both xlen_64 builds ran clean"
